// ==== design/mcu_bridge_macros.svh ====
`ifndef MCU_BRIDGE_MACROS_SVH
`define MCU_BRIDGE_MACROS_SVH

// field widths
`define MCU_BYTE_W 8
`define MCU_WORD_W 16
`define MCU_ADDR_W 24

// serial frame lengths in host_clk bits
`define MCU_RX_BITS 17 // start + cmd + dat
`define MCU_TX_BITS 18 // start + lo + hi + stop

// register load commands
`define MCU_CMD_DATA0 8'h10
`define MCU_CMD_DATA1 8'h11
`define MCU_CMD_ADDR0 8'h12
`define MCU_CMD_ADDR1 8'h13
`define MCU_CMD_ADDR2 8'h14

// display control commands
`define MCU_CMD_MODE_VGA 8'h21 // 640x480
`define MCU_CMD_MODE_XGA 8'h22 // 1024x768
`define MCU_CMD_BLANK_ON 8'h23
`define MCU_CMD_BLANK_OFF 8'h24

// single word memory access
`define MCU_CMD_MEM_WRITE 8'hA0
`define MCU_CMD_MEM_READ 8'hA1

`endif

// ==== design/mcu_bridge_pkg.sv ====
`default_nettype none

`include "mcu_bridge_macros.svh"

package mcu_bridge_pkg;

  // one command frame from the host
  typedef struct packed {
    logic [`MCU_BYTE_W-1:0] cmd;
    logic [`MCU_BYTE_W-1:0] dat;
  } host_frame_t;

  // reply word, hi in the upper byte so the struct reads as the word
  typedef struct packed {
    logic [`MCU_BYTE_W-1:0] hi;
    logic [`MCU_BYTE_W-1:0] lo;
  } host_reply_t;

  // request toward the external memory controller
  typedef struct packed {
    logic [`MCU_ADDR_W-1:0] addr;
    logic [`MCU_WORD_W-1:0] wdata;
    logic                   write; // 1 write, 0 read
  } mem_req_t;

endpackage

`default_nettype wire

// ==== design/hs_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module hs_sync #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     sys_rst_n,
  input  wire logic     req,
  input  wire payload_t payload,
  output logic          ack,
  output logic          valid,
  output payload_t      data
);

  logic req_meta;
  logic req_sync;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
      valid    <= 1'b0;
      ack      <= 1'b0;
    end else begin
      req_meta <= req;
      req_sync <= req_meta;
      valid    <= req_meta && !req_sync; // rising edge of the request
      ack      <= req_sync; // one cycle behind the synced request
    end
  end

  // payload is held by the source while req is high
  always_ff @(posedge clk) begin
    if (req_meta && !req_sync) begin
      data <= payload;
    end
  end

endmodule

`default_nettype wire

// ==== design/host_frame_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcu_bridge_macros.svh"

module host_frame_rx (
  input  wire logic                  host_clk,
  input  wire logic                  sys_rst_n,
  input  wire logic                  host_rx,
  input  wire logic                  rx_ack,
  output logic                       rx_req,
  output mcu_bridge_pkg::host_frame_t rx_frame
);

  logic [4:0]             bit_cnt;  // 0 idle, 1..16 data bits
  logic [`MCU_WORD_W-1:0] shift_q;
  logic                   ack_meta;
  logic                   ack_sync;

  // acknowledge comes from the sys_clk side
  always_ff @(posedge host_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
    end else begin
      ack_meta <= rx_ack;
      ack_sync <= ack_meta;
    end
  end

  always_ff @(posedge host_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt <= '0;
      rx_req  <= 1'b0;
    end else begin
      if (bit_cnt == '0) begin
        if (host_rx && !rx_req && !ack_sync) begin // start bit, handshake idle
          bit_cnt <= 5'd1;
        end
      end else if (bit_cnt == 5'(`MCU_RX_BITS - 1)) begin
        bit_cnt <= '0;
        rx_req  <= 1'b1; // last dat bit sampled on this edge
      end else begin
        bit_cnt <= bit_cnt + 5'd1;
      end
      if (rx_req && ack_sync) begin
        rx_req <= 1'b0;
      end
    end
  end

  // lsb first, so the first bit ends up in shift_q[0]
  always_ff @(posedge host_clk) begin
    if (bit_cnt != '0) begin
      shift_q <= {host_rx, shift_q[`MCU_WORD_W-1:1]};
    end
  end

  assign rx_frame = '{cmd: shift_q[`MCU_BYTE_W-1:0], dat: shift_q[`MCU_WORD_W-1:`MCU_BYTE_W]};

endmodule

`default_nettype wire

// ==== design/host_frame_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcu_bridge_macros.svh"

module host_frame_tx (
  input  wire logic                         host_clk,
  input  wire logic                         sys_rst_n,
  input  wire logic                         start,
  input  wire mcu_bridge_pkg::host_reply_t  reply,
  output logic                              host_tx
);

  logic [4:0]             bit_cnt;  // 0 idle, 1 start, 2..17 data, 18 stop
  logic [`MCU_WORD_W-1:0] shift_q;
  logic                   last_bit;

  assign last_bit = (bit_cnt == 5'(`MCU_TX_BITS));

  always_ff @(posedge host_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt <= '0;
      host_tx <= 1'b0; // line idles low
    end else begin
      if (bit_cnt == '0) begin
        if (start) begin
          bit_cnt <= 5'd1;
        end
      end else begin
        if (bit_cnt == 5'd1) begin
          host_tx <= 1'b1;
        end else if (last_bit) begin
          host_tx <= 1'b0;
        end else begin
          host_tx <= shift_q[0];
        end

        if (last_bit) begin
          bit_cnt <= '0;
        end else begin
          bit_cnt <= bit_cnt + 5'd1;
        end
      end
    end
  end

  // start pulses during a frame are dropped by the idle check
  always_ff @(posedge host_clk) begin
    if (bit_cnt == '0 && start) begin
      shift_q <= {reply.hi, reply.lo}; // lo goes out first
    end else if (bit_cnt > 5'd1) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== design/cmd_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcu_bridge_macros.svh"

module cmd_exec (
  input  wire logic                        sys_clk,
  input  wire logic                        sys_rst_n,
  input  wire logic                        frame_valid,
  input  wire mcu_bridge_pkg::host_frame_t frame,
  input  wire logic                        mem_ack,
  input  wire logic [`MCU_WORD_W-1:0]      mem_rdata,
  input  wire logic                        tx_ack,
  output logic                             busy,
  output logic                             mem_req,
  output logic                             tx_req,
  output mcu_bridge_pkg::mem_req_t         mem_cmd,
  output mcu_bridge_pkg::host_reply_t      tx_reply,
  output logic                             video_mode,
  output logic                             video_blank
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_ACK,  // mem_req high, waiting for mem_ack
    S_DROP  // mem_req low, waiting for mem_ack to fall
  } state_t;

  state_t                state;
  logic [`MCU_BYTE_W-1:0] cmd_q;
  logic [`MCU_BYTE_W-1:0] dat_q;
  logic [`MCU_BYTE_W-1:0] data0;
  logic [`MCU_BYTE_W-1:0] data1;
  logic [`MCU_BYTE_W-1:0] addr0;
  logic [`MCU_BYTE_W-1:0] addr1;
  logic [`MCU_BYTE_W-1:0] addr2;
  logic                   tx_ack_meta;
  logic                   tx_ack_sync;

  assign busy = frame_valid || (state != S_IDLE);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_ack_meta <= 1'b0;
      tx_ack_sync <= 1'b0;
    end else begin
      tx_ack_meta <= tx_ack;
      tx_ack_sync <= tx_ack_meta;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= S_IDLE;
      cmd_q       <= '0;
      data0       <= '0;
      data1       <= '0;
      addr0       <= '0;
      addr1       <= '0;
      addr2       <= '0;
      mem_req     <= 1'b0;
      tx_req      <= 1'b0;
      video_mode  <= 1'b1;
      video_blank <= 1'b1;
    end else begin
      if (tx_req && tx_ack_sync) begin
        tx_req <= 1'b0;
      end

      case (state)
        S_IDLE: begin
          if (frame_valid) begin
            cmd_q <= frame.cmd;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          state <= S_IDLE; // register commands finish here
          cmd_q <= '0;
          case (cmd_q)
            `MCU_CMD_DATA0:     data0 <= dat_q;
            `MCU_CMD_DATA1:     data1 <= dat_q;
            `MCU_CMD_ADDR0:     addr0 <= dat_q;
            `MCU_CMD_ADDR1:     addr1 <= dat_q;
            `MCU_CMD_ADDR2:     addr2 <= dat_q;
            `MCU_CMD_MODE_VGA:  video_mode <= 1'b0;
            `MCU_CMD_MODE_XGA:  video_mode <= 1'b1;
            `MCU_CMD_BLANK_ON:  video_blank <= 1'b1;
            `MCU_CMD_BLANK_OFF: video_blank <= 1'b0;
            `MCU_CMD_MEM_WRITE, `MCU_CMD_MEM_READ: begin
              mem_req <= 1'b1;
              cmd_q   <= cmd_q; // kept to tell read from write later
              state   <= S_ACK;
            end
            default: ; // unknown code, nothing to do
          endcase
        end
        S_ACK: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= S_DROP;
          end
        end
        S_DROP: begin
          if (!mem_ack) begin
            state <= S_IDLE;
            cmd_q <= '0;
            if (cmd_q == `MCU_CMD_MEM_READ) begin
              tx_req <= 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge sys_clk) begin
    if (state == S_IDLE && frame_valid) begin
      dat_q <= frame.dat;
    end
    if (state == S_EXEC) begin
      mem_cmd.addr  <= {addr2, addr1, addr0};
      mem_cmd.wdata <= {data1, data0};
      mem_cmd.write <= (cmd_q == `MCU_CMD_MEM_WRITE);
    end
    if (state == S_ACK && mem_ack && !mem_cmd.write) begin
      tx_reply.hi <= mem_rdata[`MCU_WORD_W-1:`MCU_BYTE_W];
      tx_reply.lo <= mem_rdata[`MCU_BYTE_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== design/mcu_bridge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcu_bridge_macros.svh"

module mcu_bridge_top (
  input  wire logic                   sys_clk,
  input  wire logic                   sys_rst_n,
  input  wire logic                   host_clk,
  input  wire logic                   host_rx,
  input  wire logic                   mem_ack,
  input  wire logic [`MCU_WORD_W-1:0] mem_rdata,
  output logic                        host_tx,
  output logic                        busy,
  output logic                        mem_req,
  output mcu_bridge_pkg::mem_req_t    mem_cmd,
  output logic                        video_mode,
  output logic                        video_blank
);

  // host to system crossing
  logic                        rx_req;
  logic                        rx_ack;
  mcu_bridge_pkg::host_frame_t rx_frame;
  logic                        frame_valid;
  mcu_bridge_pkg::host_frame_t frame;

  // system to host crossing
  logic                        tx_req;
  logic                        tx_ack;
  mcu_bridge_pkg::host_reply_t tx_reply;
  logic                        tx_start;
  mcu_bridge_pkg::host_reply_t tx_data;

  host_frame_rx host_frame_rx_i (
    .host_clk  (host_clk),
    .sys_rst_n (sys_rst_n),
    .host_rx   (host_rx),
    .rx_ack    (rx_ack),
    .rx_req    (rx_req),
    .rx_frame  (rx_frame)
  );

  hs_sync #(.payload_t(mcu_bridge_pkg::host_frame_t)) rx_sync_i (
    .clk       (sys_clk),
    .sys_rst_n (sys_rst_n),
    .req       (rx_req),
    .payload   (rx_frame),
    .ack       (rx_ack),
    .valid     (frame_valid),
    .data      (frame)
  );

  cmd_exec cmd_exec_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .frame_valid (frame_valid),
    .frame       (frame),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .tx_ack      (tx_ack),
    .busy        (busy),
    .mem_req     (mem_req),
    .tx_req      (tx_req),
    .mem_cmd     (mem_cmd),
    .tx_reply    (tx_reply),
    .video_mode  (video_mode),
    .video_blank (video_blank)
  );

  hs_sync #(.payload_t(mcu_bridge_pkg::host_reply_t)) tx_sync_i (
    .clk       (host_clk),
    .sys_rst_n (sys_rst_n),
    .req       (tx_req),
    .payload   (tx_reply),
    .ack       (tx_ack),
    .valid     (tx_start),
    .data      (tx_data)
  );

  host_frame_tx host_frame_tx_i (
    .host_clk  (host_clk),
    .sys_rst_n (sys_rst_n),
    .start     (tx_start),
    .reply     (tx_data),
    .host_tx   (host_tx)
  );

endmodule

`default_nettype wire

// ==== verif/mcu_bridge_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcu_bridge_assert (
  input wire logic                     sys_clk,
  input wire logic                     sys_rst_n,
  input wire logic                     busy,
  input wire logic                     mem_req,
  input wire logic                     mem_ack,
  input wire mcu_bridge_pkg::mem_req_t mem_cmd
);

  // request payload held until the request drops
  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    mem_req |=> (!mem_req || $stable(mem_cmd)))
    else $error("mem_cmd changed while mem_req was high");

  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    $rose(mem_ack) |-> mem_req)
    else $error("mem_ack rose without mem_req");

  // ack may only linger for its falling cycle
  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    (mem_ack && !mem_req) |=> !mem_ack)
    else $error("mem_ack stayed high after mem_req fell");

  assert property (@(posedge sys_clk) $rose(sys_rst_n) |-> !busy)
    else $error("busy high in the first cycle after reset");

endmodule

bind mcu_bridge_top mcu_bridge_assert mcu_bridge_assert_i (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .busy      (busy),
  .mem_req   (mem_req),
  .mem_ack   (mem_ack),
  .mem_cmd   (mem_cmd)
);

`default_nettype wire

// ==== verif/mcu_bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcu_bridge_macros.svh"

module mcu_bridge_tb;

  localparam int HOST_DIV = 10; // sys_clk cycles per host_clk period

  logic                        sys_clk;
  logic                        sys_rst_n;
  logic                        host_clk;
  logic                        host_rx;
  logic                        mem_ack;
  logic [`MCU_WORD_W-1:0]      mem_rdata;
  logic                        host_tx;
  logic                        busy;
  logic                        mem_req;
  mcu_bridge_pkg::mem_req_t    mem_cmd;
  logic                        video_mode;
  logic                        video_blank;

  logic [`MCU_WORD_W-1:0]      mem_words [logic [`MCU_ADDR_W-1:0]];
  mcu_bridge_pkg::mem_req_t    mem_log [$];
  mcu_bridge_pkg::mem_req_t    cmd_seen;
  mcu_bridge_pkg::host_reply_t reply_q [$];
  logic [`MCU_WORD_W-1:0]      rep_shift;
  logic                        busy_seen = 1'b0;
  int                          rep_cnt = 0;
  int                          busy_rises = 0;
  int                          cycle_cnt = 0;
  int                          limit_cycles = 0;
  int                          case_errs = 0;
  int                          total_errs = 0;
  int                          n_pass = 0;
  int                          n_tests = 0;

  mcu_bridge_top mcu_bridge_top_i (.*);

  always #20 sys_clk = ~sys_clk;
  always #(20 * HOST_DIV) host_clk = ~host_clk;

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
      $display("run stopped after %0d sys_clk cycles, the tests did not finish", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  always @(negedge sys_clk) begin
    if (busy && !busy_seen) busy_rises++;
    busy_seen = busy;
  end

  // reply frame is a start bit then lo and hi lsb first then a stop bit
  always @(negedge host_clk) begin
    if (rep_cnt == 0) begin
      if (sys_rst_n && host_tx) rep_cnt = 1;
    end else if (rep_cnt <= `MCU_WORD_W) begin
      rep_shift = {host_tx, rep_shift[`MCU_WORD_W-1:1]};
      rep_cnt++;
    end else begin
      if (host_tx !== 1'b0) begin
        $display("reply frame ended without a stop bit");
        case_errs++;
      end
      reply_q.push_back(mcu_bridge_pkg::host_reply_t'(rep_shift));
      rep_cnt = 0;
    end
  end

  // external memory controller acks three cycles after the request
  always begin
    @(negedge sys_clk);
    if (sys_rst_n && mem_req && !mem_ack) begin
      cmd_seen = mem_cmd;
      mem_log.push_back(cmd_seen);
      repeat (3) @(posedge sys_clk);
      #1;
      if (cmd_seen.write) begin
        mem_words[cmd_seen.addr] = cmd_seen.wdata;
        $display("memory write %h <= %h", cmd_seen.addr, cmd_seen.wdata);
      end else begin
        mem_rdata = mem_word_at(cmd_seen.addr);
      end
      mem_ack = 1'b1;
      while (mem_req) @(negedge sys_clk);
      @(posedge sys_clk);
      #1 mem_ack = 1'b0;
      mem_rdata = '0;
    end
  end

  function automatic logic [`MCU_WORD_W-1:0] mem_word_at(input logic [`MCU_ADDR_W-1:0] a);
    if (mem_words.exists(a)) return mem_words[a];
    return {a[7:0] ^ a[23:16], a[15:8] ^ 8'h5a}; // untouched words
  endfunction

  task automatic check_mem_req(input string name, input mcu_bridge_pkg::mem_req_t exp,
                               input mcu_bridge_pkg::mem_req_t act);
    if (act !== exp) begin
      $display("[FAIL] %s mem_cmd expected %h actual %h", name, exp, act);
      case_errs++;
    end
  endtask

  task automatic check_reply(input string name, input mcu_bridge_pkg::host_reply_t exp,
                             input mcu_bridge_pkg::host_reply_t act);
    if (act !== exp) begin
      $display("[FAIL] %s reply expected %h actual %h", name, exp, act);
      case_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [`MCU_WORD_W-1:0] exp,
                            input logic [`MCU_WORD_W-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s memory word expected %h actual %h", name, exp, act);
      case_errs++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s %s expected %b actual %b", name, what, exp, act);
      case_errs++;
    end
  endtask

  task automatic send_frame(input string name, input mcu_bridge_pkg::host_frame_t f);
    logic [`MCU_WORD_W-1:0] bits;
    int                     rises_before;
    int                     waited;
    bits = {f.dat, f.cmd}; // cmd goes out first
    rises_before = busy_rises;
    @(posedge host_clk);
    #1 host_rx = 1'b1;
    for (int i = 0; i < `MCU_WORD_W; i++) begin
      @(posedge host_clk);
      #1 host_rx = bits[i];
    end
    @(posedge host_clk);
    #1 host_rx = 1'b0;
    waited = 0;
    while ((busy_rises == rises_before || busy_seen) && waited < 100 * HOST_DIV) begin
      @(posedge sys_clk);
      waited++;
    end
    if (waited >= 100 * HOST_DIV) begin
      $display("%s: busy did not rise and fall again after frame %h", name, f);
      case_errs++;
    end
    repeat (8) @(posedge host_clk); // receiver handshake back to idle
  endtask

  task automatic run_case(input string line);
    string                    name;
    string                    kind;
    int                       n;
    logic [`MCU_WORD_W-1:0]   fr [6];
    logic [`MCU_ADDR_W-1:0]   addr;
    logic [`MCU_WORD_W-1:0]   wdata;
    logic [`MCU_WORD_W-1:0]   word;
    logic [1:0]               flags;
    mcu_bridge_pkg::mem_req_t exp_req;
    void'($sscanf(line, "%s %s %d %h %h %h %h %h %h %h %h %h %b", name, kind, n,
                  fr[0], fr[1], fr[2], fr[3], fr[4], fr[5], addr, wdata, word, flags));
    case_errs = 0;
    for (int i = 0; i < n; i++) send_frame(name, mcu_bridge_pkg::host_frame_t'(fr[i]));
    repeat (30) @(posedge host_clk); // room for a whole reply frame
    @(posedge sys_clk);
    @(negedge sys_clk);
    check_flag(name, "busy", 1'b0, busy);
    check_flag(name, "mem_req", 1'b0, mem_req);
    check_flag(name, "host_tx", 1'b0, host_tx);
    check_flag(name, "video_mode", flags[1], video_mode);
    check_flag(name, "video_blank", flags[0], video_blank);
    exp_req.addr  = addr;
    exp_req.wdata = wdata;
    exp_req.write = (kind == "write");
    if (mem_log.size() != ((kind == "flags") ? 0 : 1)) begin
      $display("%s: wrong number of memory requests, saw %0d", name, mem_log.size());
      case_errs++;
    end else if (kind != "flags") begin
      check_mem_req(name, exp_req, mem_log[0]);
    end
    if (reply_q.size() != ((kind == "read") ? 1 : 0)) begin
      $display("%s: wrong number of reply frames, saw %0d", name, reply_q.size());
      case_errs++;
    end else if (kind == "read") begin
      check_reply(name, mcu_bridge_pkg::host_reply_t'(word), reply_q[0]);
    end
    if (kind == "write") check_word(name, word, mem_word_at(addr));
    mem_log.delete();
    reply_q.delete();
    total_errs += case_errs;
    if (case_errs == 0) begin
      $display("test %s ok", name);
      n_pass++;
    end else begin
      $display("test %s: %0d errors", name, case_errs);
    end
  endtask

  // first pass loads memory and counts tests and the second pass runs them
  task automatic walk_cases(input bit run);
    int                     fd;
    string                  line;
    string                  tok;
    logic [`MCU_ADDR_W-1:0] a;
    logic [`MCU_WORD_W-1:0] w;
    fd = $fopen("verif/mcu_bridge_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/mcu_bridge_cases.txt");
      total_errs++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%s", tok) != 1 || tok.substr(0, 0) == "#") continue;
      if (tok == "load") begin
        if (!run) begin
          void'($sscanf(line, "%s %h %h", tok, a, w));
          mem_words[a] = w;
        end
      end else if (run) begin
        run_case(line);
      end else begin
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    sys_clk   = 1'b0;
    host_clk  = 1'b0;
    sys_rst_n = 1'b0;
    host_rx   = 1'b0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    walk_cases(1'b0);
    limit_cycles = n_tests * 60 * HOST_DIV * 10; // tenfold margin on 60 host periods a test
    repeat (2) @(posedge sys_clk);
    #1 sys_rst_n = 1'b1;
    @(posedge sys_clk);
    walk_cases(1'b1);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_pass, n_tests - n_pass, total_errs);
    if (total_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mcu_bridge_cases.txt ====
# name kind nframes f0..f5 (cmd:dat hex) addr wdata word flags (mode blank)
# load addr word puts a word into the memory model before the tests
load 012345 ffff
load 00a0f0 5ac3
load 7f0010 c0de
reset_values      flags 0 0000 0000 0000 0000 0000 0000 000000 0000 0000 11
write_word        write 6 1034 1112 1245 1323 1401 a000 012345 1234 1234 11
read_preload      read  4 12f0 13a0 1400 a100 0000 0000 00a0f0 1234 5ac3 11
read_back         read  4 1245 1323 1401 a100 0000 0000 012345 1234 1234 11
read_high_addr    read  4 1210 1300 147f a100 0000 0000 7f0010 1234 c0de 11
mode_vga          flags 1 2100 0000 0000 0000 0000 0000 000000 0000 0000 01
blank_off         flags 1 2400 0000 0000 0000 0000 0000 000000 0000 0000 00
mode_xga          flags 1 2200 0000 0000 0000 0000 0000 000000 0000 0000 10
blank_on          flags 1 2300 0000 0000 0000 0000 0000 000000 0000 0000 11
unknown_cmd       flags 1 5577 0000 0000 0000 0000 0000 000000 0000 0000 11
write_zero_addr   write 6 10ef 11be 1200 1300 1400 a000 000000 beef beef 11
unknown_then_read read  2 5500 a100 0000 0000 0000 0000 000000 beef beef 11

// ==== mcu_bridge_top.f ====
+incdir+design
design/mcu_bridge_pkg.sv
design/hs_sync.sv
design/host_frame_rx.sv
design/host_frame_tx.sv
design/cmd_exec.sv
design/mcu_bridge_top.sv
verif/mcu_bridge_assert.sv
verif/mcu_bridge_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mcu_bridge_tb
FILELIST = mcu_bridge_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failures found" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
